// File: classifier_top.f
nn_pkg.sv
img_ctx_if.sv
classify_fsm.sv
activity_timer.sv
output_buffer.sv
argmax_tree.sv
score_tracker.sv
classifier_top.sv
classifier_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= classifier_tb
FILELIST  ?= classifier_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@grep -q "Test completed successfully" $(LOG) || (echo "simulation ended early"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: classifier_tb.sv
module classifier_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int LANES        = 2;
  localparam int CYCLE_WIDTH  = 32;
  localparam int NUM_ROWS     = 8;
  localparam int RESET_CYCLES = 5;
  localparam int HALF_PERIOD  = 50;
  localparam int MAX_LATENCY  = 7;
  localparam logic [15:0] LFSR_TAPS = 16'hB400;

  logic                           clk;
  logic                           reset;
  logic                           start_i;
  logic                           img_valid_i;
  nn_pkg::img_id_t                img_id_i;
  nn_pkg::neuron_id_t             img_label_i;
  logic                           training_mode_i;
  logic                           act_valid_i;
  nn_pkg::act_t       [LANES-1:0] act_i;
  nn_pkg::neuron_id_t [LANES-1:0] neuron_id_i;
  logic                           img_ready_o;
  logic                           result_valid_o;
  logic                           correct_o;
  logic [nn_pkg::NUM_LEDS-1:0]    led_o;
  nn_pkg::count_t                 num_correct_train_o;
  nn_pkg::count_t                 num_correct_test_o;
  nn_pkg::epoch_t                 epoch_o;
  logic [CYCLE_WIDTH-1:0]         active_cycles_o;
  logic [CYCLE_WIDTH-1:0]         idle_cycles_o;

  // activations in units of 1/16
  // row_rand rows take LFSR values instead
  nn_pkg::img_id_t    row_id    [NUM_ROWS] = '{0, 1, 2, 3, 0, 1, 2, 3};
  nn_pkg::neuron_id_t row_label [NUM_ROWS] = '{3, 5, 9, 1, 0, 7, 4, 8};
  logic               row_train [NUM_ROWS] = '{1, 1, 0, 0, 1, 1, 0, 0};
  logic               row_rand  [NUM_ROWS] = '{0, 0, 0, 1, 0, 1, 0, 0};
  int row_acts [NUM_ROWS][nn_pkg::NUM_CLASSES] = '{
    '{1, -2, 3, 30, 4, 5, -6, 7, 8, 9},
    '{2, 1, 20, 3, -1, 20, 4, 5, 6, 7},
    '{-1, 2, 3, 4, 5, 6, 7, 8, 9, 25},
    '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0},
    '{40, 1, 2, 3, 4, 5, 6, 7, 8, 9},
    '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0},
    '{-9, -8, -7, -6, -1, -5, -4, -3, -2, -10},
    '{1, 2, 3, 4, 5, 6, 7, 8, 12, 12}
  };

  logic [15:0]     lfsr = 16'd10411;
  int              errors = 0;
  int              failed_tests = 0;
  int              run_cycles = 0;
  int              result_pulses = 0;
  nn_pkg::count_t  exp_train = '0;
  nn_pkg::count_t  exp_test = '0;
  nn_pkg::epoch_t  exp_epoch = '0;
  nn_pkg::img_id_t prev_id = '0;

  classifier_top #(.LANES(LANES), .CYCLE_WIDTH(CYCLE_WIDTH)) UUT (.*);

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  // reference for the activity counters
  always @(posedge clk) begin
    if (!start_i) begin
      run_cycles <= 0;
    end else begin
      run_cycles <= run_cycles + 1;
    end
  end

  // every image should give exactly one result strobe
  always @(negedge clk) begin
    if (result_valid_o) begin
      result_pulses <= result_pulses + 1;
    end
  end

  initial begin
    #(2 * HALF_PERIOD * (NUM_ROWS * 40 + RESET_CYCLES));
    $display("watchdog expired before the tests finished");
    $display("Test failed");
    $finish;
  end

  task automatic check_leds(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns %s: got %b, expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns %s: got %b, expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input nn_pkg::count_t got,
                             input nn_pkg::count_t exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns %s: got %0d, expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_epoch(input string name, input nn_pkg::epoch_t got,
                             input nn_pkg::epoch_t exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns %s: got %0d, expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_cycles(input string name, input logic [CYCLE_WIDTH-1:0] got,
                              input logic [CYCLE_WIDTH-1:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns %s: got %0d, expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  task automatic random_act(output nn_pkg::act_t v);
    for (int i = 0; i < nn_pkg::PREC; i++) begin
      lfsr = lfsr_step(lfsr);
      v[i] = lfsr[0];
    end
  endtask

  // winner mask and judgment straight from the classification rules
  task automatic predict(input nn_pkg::act_t a [nn_pkg::NUM_CLASSES],
                         input nn_pkg::neuron_id_t label,
                         output logic [7:0] leds, output logic ok);
    nn_pkg::act_t top;
    int           hits;
    top  = a[0];
    hits = 0;
    leds = '0;
    for (int k = 1; k < nn_pkg::NUM_CLASSES; k++) begin
      if (a[k] > top) top = a[k];
    end
    for (int k = 0; k < nn_pkg::NUM_CLASSES; k++) begin
      if (a[k] == top) begin
        hits++;
        if (k < nn_pkg::NUM_LEDS) leds[k] = 1'b1;
      end
    end
    ok = (a[label] == top) && (hits == 1);
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d mismatches", name, errors - errors_before);
      failed_tests++;
    end
  endtask

  task automatic run_row(input int r);
    nn_pkg::act_t acts [nn_pkg::NUM_CLASSES];
    logic [7:0]   exp_leds;
    logic         exp_ok;
    int           lat;
    int           errors_before;
    errors_before = errors;
    for (int k = 0; k < nn_pkg::NUM_CLASSES; k++) begin
      if (row_rand[r]) random_act(acts[k]);
      else acts[k] = nn_pkg::act_t'(row_acts[r][k] * 256);
    end
    predict(acts, row_label[r], exp_leds, exp_ok);
    @(negedge clk);
    while (!img_ready_o) @(negedge clk);
    // stray beat while idle with id 9 on the last lane
    @(posedge clk);
    act_valid_i <= 1'b1;
    neuron_id_i <= {4'd9, 4'd8};
    act_i       <= {18'sh1ffff, 18'sh1ffff};
    @(posedge clk);
    act_valid_i     <= 1'b0;
    img_valid_i     <= 1'b1;
    img_id_i        <= row_id[r];
    img_label_i     <= row_label[r];
    training_mode_i <= row_train[r];
    if (row_id[r] == '0 && prev_id != '0) begin
      exp_epoch++;
      exp_train = '0;
      exp_test  = '0;
    end
    prev_id = row_id[r];
    @(posedge clk);
    img_valid_i <= 1'b0;
    for (int b = 0; b < nn_pkg::NUM_CLASSES / LANES; b++) begin
      act_valid_i <= 1'b1;
      neuron_id_i <= {nn_pkg::neuron_id_t'(2 * b + 1), nn_pkg::neuron_id_t'(2 * b)};
      act_i       <= {acts[2 * b + 1], acts[2 * b]};
      @(posedge clk);
    end
    act_valid_i <= 1'b0;
    lat = 0;
    do begin
      @(posedge clk);
      lat++;
      if (lat == 1) begin
        // image and beat offered while ranking must be dropped
        act_valid_i <= 1'b1;
        neuron_id_i <= {4'd1, 4'd0};
        act_i       <= {18'sh1ffff, 18'sh1ffff};
        img_valid_i <= 1'b1;
        img_id_i    <= '0;
        img_label_i <= 4'd2;
      end else if (lat == 2) begin
        act_valid_i <= 1'b0;
        img_valid_i <= 1'b0;
      end
      @(negedge clk);
    end while (!result_valid_o && lat < MAX_LATENCY);
    if (!result_valid_o) begin
      $display("image %0d: no result within %0d cycles of the last beat", r, MAX_LATENCY);
      errors++;
    end
    check_leds("led_o", led_o, exp_leds);
    check_bit("correct_o", correct_o, exp_ok);
    if (exp_ok && row_train[r]) exp_train++;
    else if (exp_ok) exp_test++;
    @(posedge clk);
    @(negedge clk);
    check_count("num_correct_train_o", num_correct_train_o, exp_train);
    check_count("num_correct_test_o", num_correct_test_o, exp_test);
    check_epoch("epoch_o", epoch_o, exp_epoch);
    check_cycles("active+idle cycles", active_cycles_o + idle_cycles_o, run_cycles);
    check_cycles("result_valid_o pulses", result_pulses, r + 1);
    report_test($sformatf("row %0d image %0d label %0d", r, row_id[r], row_label[r]),
                errors_before);
  endtask

  initial begin
    int errors_before;
    reset           = 1'b1;
    start_i         = 1'b0;
    img_valid_i     = 1'b0;
    img_id_i        = '0;
    img_label_i     = '0;
    training_mode_i = 1'b0;
    act_valid_i     = 1'b0;
    act_i           = '0;
    neuron_id_i     = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset   <= 1'b0;
    start_i <= 1'b1;
    @(negedge clk);
    errors_before = errors;
    check_bit("img_ready_o", img_ready_o, 1'b1);
    check_bit("result_valid_o", result_valid_o, 1'b0);
    check_bit("correct_o", correct_o, 1'b0);
    check_leds("led_o", led_o, 8'h00);
    check_count("num_correct_train_o", num_correct_train_o, '0);
    check_count("num_correct_test_o", num_correct_test_o, '0);
    check_epoch("epoch_o", epoch_o, '0);
    report_test("reset values", errors_before);
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(r);
    end
    // dropping start clears the activity counters
    errors_before = errors;
    @(posedge clk);
    start_i <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    check_cycles("active_cycles_o", active_cycles_o, '0);
    check_cycles("idle_cycles_o", idle_cycles_o, '0);
    report_test("activity clear", errors_before);
    $display("summary: %0d tests, %0d failed, %0d check errors",
             NUM_ROWS + 2, failed_tests, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: classifier_top.sv
module classifier_top #(
  parameter int LANES       = 2,
  parameter int CYCLE_WIDTH = 32
) (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              start_i,
  input  logic                              img_valid_i,
  input  nn_pkg::img_id_t                   img_id_i,
  input  nn_pkg::neuron_id_t                img_label_i,
  input  logic                              training_mode_i,
  input  logic                              act_valid_i,
  input  nn_pkg::act_t       [LANES-1:0]    act_i,
  input  nn_pkg::neuron_id_t [LANES-1:0]    neuron_id_i,
  output logic                              img_ready_o,
  output logic                              result_valid_o,
  output logic                              correct_o,
  output logic [nn_pkg::NUM_LEDS-1:0]       led_o,
  output nn_pkg::count_t                    num_correct_train_o,
  output nn_pkg::count_t                    num_correct_test_o,
  output nn_pkg::epoch_t                    epoch_o,
  output logic [CYCLE_WIDTH-1:0]            active_cycles_o,
  output logic [CYCLE_WIDTH-1:0]            idle_cycles_o
);

  logic                                   collect;
  logic                                   busy;
  logic                                   buf_complete;
  nn_pkg::act_t [nn_pkg::NUM_CLASSES-1:0] acts;

  img_ctx_if ctx_if ();

  classify_fsm u_fsm (
    .clk             (clk),
    .reset           (reset),
    .start_i         (start_i),
    .img_valid_i     (img_valid_i),
    .img_id_i        (img_id_i),
    .img_label_i     (img_label_i),
    .training_mode_i (training_mode_i),
    .buf_complete_i  (buf_complete),
    .result_valid_i  (result_valid_o),
    .collect_o       (collect),
    .busy_o          (busy),
    .img_ready_o     (img_ready_o),
    .ctx             (ctx_if.fsm)
  );

  output_buffer #(.LANES(LANES)) u_buffer (
    .clk         (clk),
    .reset       (reset),
    .collect_i   (collect),
    .act_valid_i (act_valid_i),
    .act_i       (act_i),
    .neuron_id_i (neuron_id_i),
    .complete_o  (buf_complete),
    .acts_o      (acts)
  );

  argmax_tree u_argmax (
    .clk            (clk),
    .reset          (reset),
    .complete_i     (buf_complete),
    .acts_i         (acts),
    .ctx            (ctx_if.data),
    .result_valid_o (result_valid_o),
    .correct_o      (correct_o),
    .led_o          (led_o)
  );

  score_tracker u_score (
    .clk                 (clk),
    .reset               (reset),
    .ctx                 (ctx_if.data),
    .result_valid_i      (result_valid_o),
    .correct_i           (correct_o),
    .num_correct_train_o (num_correct_train_o),
    .num_correct_test_o  (num_correct_test_o),
    .epoch_o             (epoch_o)
  );

  activity_timer #(.CYCLE_WIDTH(CYCLE_WIDTH)) u_timer (
    .clk             (clk),
    .reset           (reset),
    .start_i         (start_i),
    .busy_i          (busy),
    .active_cycles_o (active_cycles_o),
    .idle_cycles_o   (idle_cycles_o)
  );

endmodule

// File: score_tracker.sv
module score_tracker (
  input  logic           clk,
  input  logic           reset,
  img_ctx_if.data        ctx,
  input  logic           result_valid_i,
  input  logic           correct_i,
  output nn_pkg::count_t num_correct_train_o,
  output nn_pkg::count_t num_correct_test_o,
  output nn_pkg::epoch_t epoch_o
);

  nn_pkg::img_id_t prev_id;
  logic            new_epoch;

  // set wraps back to image zero
  assign new_epoch = ctx.load && (ctx.img_id == '0) && (prev_id != '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      prev_id <= '0;
    end else if (ctx.load) begin
      prev_id <= ctx.img_id;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      epoch_o             <= '0;
      num_correct_train_o <= '0;
      num_correct_test_o  <= '0;
    end else if (new_epoch) begin
      epoch_o             <= epoch_o + 1'b1;
      num_correct_train_o <= '0;
      num_correct_test_o  <= '0;
    end else if (result_valid_i && correct_i) begin
      if (ctx.training_mode) begin
        num_correct_train_o <= num_correct_train_o + 1'b1;
      end else begin
        num_correct_test_o  <= num_correct_test_o + 1'b1;
      end
    end
  end

endmodule

// File: argmax_tree.sv
module argmax_tree (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic                                   complete_i,
  input  nn_pkg::act_t [nn_pkg::NUM_CLASSES-1:0] acts_i,
  img_ctx_if.data                                ctx,
  output logic                                   result_valid_o,
  output logic                                   correct_o,
  output logic [nn_pkg::NUM_LEDS-1:0]            led_o
);

  localparam int STAGES = 5;

  nn_pkg::act_t [4:0]              max1;
  nn_pkg::act_t [2:0]              max2;
  nn_pkg::act_t [1:0]              max3;
  nn_pkg::act_t                    max4;
  nn_pkg::act_t                    max_q;
  logic [STAGES-1:0]               vld;
  logic [nn_pkg::NUM_CLASSES-1:0]  match;
  logic                            label_hit;
  logic                            other_hit;

  // signed compare, act_t carries the sign
  function automatic nn_pkg::act_t pick_max(input nn_pkg::act_t a, input nn_pkg::act_t b);
    return (a > b) ? a : b;
  endfunction

  // 10 -> 5 -> 3 -> 2 -> 1, then one more register
  always_ff @(posedge clk) begin
    for (int k = 0; k < 5; k++) begin
      max1[k] <= pick_max(acts_i[2*k], acts_i[2*k+1]);
    end
    max2[0] <= pick_max(max1[0], max1[1]);
    max2[1] <= pick_max(max1[2], max1[3]);
    max2[2] <= max1[4];
    max3[0] <= pick_max(max2[0], max2[1]);
    max3[1] <= max2[2];
    max4    <= pick_max(max3[0], max3[1]);
    max_q   <= max4;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      vld <= '0;
    end else begin
      vld <= {vld[STAGES-2:0], complete_i};
    end
  end

  // buffer is frozen while ranking, so entries are still the ones ranked
  always_comb begin
    label_hit = 1'b0;
    other_hit = 1'b0;
    for (int k = 0; k < nn_pkg::NUM_CLASSES; k++) begin
      match[k] = (acts_i[k] == max_q);
      if (k == ctx.label) begin
        label_hit = match[k];
      end else begin
        other_hit = other_hit | match[k];
      end
    end
  end

  // a tie never counts as correct
  always_ff @(posedge clk) begin
    if (reset) begin
      result_valid_o <= 1'b0;
      correct_o      <= 1'b0;
      led_o          <= '0;
    end else begin
      result_valid_o <= vld[STAGES-1];
      if (vld[STAGES-1]) begin
        correct_o <= label_hit && !other_hit;
        led_o     <= match[nn_pkg::NUM_LEDS-1:0];
      end
    end
  end

  a_no_overlap: assert property (@(posedge clk) disable iff (reset)
    complete_i |-> (vld == '0));

endmodule

// File: output_buffer.sv
module output_buffer #(
  parameter int LANES = 2
) (
  input  logic                                    clk,
  input  logic                                    reset,
  input  logic                                    collect_i,
  input  logic                                    act_valid_i,
  input  nn_pkg::act_t       [LANES-1:0]          act_i,
  input  nn_pkg::neuron_id_t [LANES-1:0]          neuron_id_i,
  output logic                                    complete_o,
  output nn_pkg::act_t       [nn_pkg::NUM_CLASSES-1:0] acts_o
);

  localparam nn_pkg::neuron_id_t LAST_ID = nn_pkg::neuron_id_t'(nn_pkg::NUM_CLASSES - 1);

  logic beat;

  // beats only count while the sequencer collects
  assign beat = collect_i && act_valid_i;

  always_ff @(posedge clk) begin
    if (beat) begin
      for (int l = 0; l < LANES; l++) begin
        if (neuron_id_i[l] < nn_pkg::NUM_CLASSES) begin
          acts_o[neuron_id_i[l]] <= act_i[l];
        end
      end
    end
  end

  // last lane carries the highest id on the final beat
  always_ff @(posedge clk) begin
    if (reset) begin
      complete_o <= 1'b0;
    end else begin
      complete_o <= beat && (neuron_id_i[LANES-1] == LAST_ID);
    end
  end

  for (genvar g = 0; g < LANES; g++) begin : g_id_check
    a_id_range: assert property (@(posedge clk) disable iff (reset)
      act_valid_i |-> (neuron_id_i[g] < nn_pkg::NUM_CLASSES));
  end

endmodule

// File: activity_timer.sv
module activity_timer #(
  parameter int CYCLE_WIDTH = 32
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   start_i,
  input  logic                   busy_i,
  output logic [CYCLE_WIDTH-1:0] active_cycles_o,
  output logic [CYCLE_WIDTH-1:0] idle_cycles_o
);

  // counts only run while a run is enabled
  always_ff @(posedge clk) begin
    if (reset || !start_i) begin
      active_cycles_o <= '0;
      idle_cycles_o   <= '0;
    end else if (busy_i) begin
      active_cycles_o <= active_cycles_o + 1'b1;
    end else begin
      idle_cycles_o   <= idle_cycles_o + 1'b1;
    end
  end

endmodule

// File: classify_fsm.sv
module classify_fsm (
  input  logic               clk,
  input  logic               reset,
  input  logic               start_i,
  input  logic               img_valid_i,
  input  nn_pkg::img_id_t    img_id_i,
  input  nn_pkg::neuron_id_t img_label_i,
  input  logic               training_mode_i,
  input  logic               buf_complete_i,
  input  logic               result_valid_i,
  output logic               collect_o,
  output logic               busy_o,
  output logic               img_ready_o,
  img_ctx_if.fsm             ctx
);

  nn_pkg::layer_state_e state;
  nn_pkg::layer_state_e next_state;
  logic                 accept;

  // images offered outside idle are simply dropped
  assign accept = (state == nn_pkg::ST_IDLE) && img_valid_i && start_i;

  always_comb begin
    case (state)
      nn_pkg::ST_IDLE:    next_state = accept ? nn_pkg::ST_COLLECT : nn_pkg::ST_IDLE;
      nn_pkg::ST_COLLECT: next_state = buf_complete_i ? nn_pkg::ST_RANK : nn_pkg::ST_COLLECT;
      nn_pkg::ST_RANK:    next_state = result_valid_i ? nn_pkg::ST_REPORT : nn_pkg::ST_RANK;
      nn_pkg::ST_REPORT:  next_state = nn_pkg::ST_IDLE;
      default:            next_state = nn_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= nn_pkg::ST_IDLE;
      ctx.load <= 1'b0;
    end else begin
      state    <= next_state;
      ctx.load <= accept;
    end
  end

  // image context held until the next accepted image
  always_ff @(posedge clk) begin
    if (accept) begin
      ctx.label         <= img_label_i;
      ctx.training_mode <= training_mode_i;
      ctx.img_id        <= img_id_i;
    end
  end

  assign img_ready_o = (state == nn_pkg::ST_IDLE);
  assign busy_o      = (state != nn_pkg::ST_IDLE);
  assign collect_o   = (state == nn_pkg::ST_COLLECT);

  // datapath strobes only arrive in the state that waits for them
  a_complete_in_collect: assert property (@(posedge clk) disable iff (reset)
    buf_complete_i |-> (state == nn_pkg::ST_COLLECT));

  a_result_in_rank: assert property (@(posedge clk) disable iff (reset)
    result_valid_i |-> (state == nn_pkg::ST_RANK));

endmodule

// File: img_ctx_if.sv
interface img_ctx_if;

  // one cycle pulse when an image is taken
  logic               load;
  nn_pkg::neuron_id_t label;
  logic               training_mode;
  nn_pkg::img_id_t    img_id;

  modport fsm (
    output load,
    output label,
    output training_mode,
    output img_id
  );

  modport data (
    input load,
    input label,
    input training_mode,
    input img_id
  );

endinterface

// File: nn_pkg.sv
package nn_pkg;

  // activation word, fixed point with 12 fraction bits
  localparam int PREC = 18;

  typedef logic signed [PREC-1:0] act_t;

  // output layer size and how many classes reach the LEDs
  localparam int NUM_CLASSES = 10;
  localparam int NUM_LEDS    = 8;

  typedef logic [3:0]  neuron_id_t;

  // image index inside one set
  typedef logic [16:0] img_id_t;

  typedef logic [16:0] count_t;
  typedef logic [9:0]  epoch_t;

  // sequencer states
  typedef enum logic [1:0] {
    ST_IDLE    = 2'd0,
    ST_COLLECT = 2'd1,
    ST_RANK    = 2'd2,
    ST_REPORT  = 2'd3
  } layer_state_e;

endpackage
